/* dv/fir_tests.svh */
	// fixed registers and idle handshake state right after reset
	task automatic test_id_regs();
		int err_start;
		err_start = errors;
		check_flag("bvalid after reset", bvalid, 1'b0);
		check_flag("rvalid after reset", rvalid, 1'b0);
		check_flag("in_ready after reset", in_ready, 1'b1);
		check_flag("out_valid after reset", out_valid, 1'b0);
		read_check("name", fir_pkg::REG_NAME, 32'h4649_5220);     // "FIR "
		read_check("version", fir_pkg::REG_VER, 32'h3032_2e33);   // "02.3"
		read_check("taps", fir_pkg::REG_TAPS, 32'd8);
		read_check("taps per lane", fir_pkg::REG_TM, 32'd4);
		read_check("lanes", fir_pkg::REG_LANES, 32'd2);
		read_check("fraction bits", fir_pkg::REG_FRAC, 32'd17);
		read_check("coefficient base", fir_pkg::REG_COEF_BASE_RD, 32'd64);
		read_check("unmapped word", 14'd3, '0);
		read_check("coefficient slot", fir_pkg::COEF_BASE + 14'd5, '0);   // write only
		read_check("switches after reset", fir_pkg::REG_SWITCHES, '0);
		check_word("leds after reset", fir_pkg::axi_data_t'(leds), '0);
		end_test("id_regs", err_start);
	endtask

	// switches readback and leds on the low byte
	task automatic test_switches();
		int err_start;
		fir_pkg::axi_data_t vals [2];
		err_start = errors;
		vals[0] = 32'h1234_56fd;
		vals[1] = 32'h0000_0036;
		for (int i = 0; i < 2; i++) begin
			set_switches(vals[i]);
			read_check("switches readback", fir_pkg::REG_SWITCHES, vals[i]);
			check_word("leds", fir_pkg::axi_data_t'(leds), vals[i] & 32'hff);
		end
		end_test("switches", err_start);
	endtask

	// bit 1 clear, samples pass through with the filter latency
	task automatic test_bypass();
		int err_start;
		err_start = errors;
		set_switches(32'h0000_00fd);   // all switches but the filter enable
		run_sample("bypass min", -14'sd8192, 0);
		run_sample("bypass max", 14'sd8191, 1);
		for (int i = 0; i < 12; i++)
			run_sample("bypass", fir_pkg::sample_t'($urandom), 0);
		end_test("bypass", err_start);
	endtask

	// impulse response, tap 0 product lands on +8192 and wraps
	task automatic test_impulse();
		int err_start;
		fir_pkg::coef_t taps [NUM_TAPS];
		err_start = errors;
		taps = '{-18'sd131072, 18'sd65536, -18'sd32768, 18'sd12345,
			-18'sd77777, 18'sd100000, 18'sd3, -18'sd1};
		for (int k = 0; k < NUM_TAPS; k++)
			write_coef(k, taps[k]);
		set_switches(32'h0000_0002);
		for (int i = 0; i < NUM_TAPS; i++)
			run_sample("flush", '0, 0);     // clear bypass leftovers from the chain
		run_sample("impulse", -14'sd8192, 0);
		for (int i = 1; i < NUM_TAPS; i++)
			run_sample("impulse tail", '0, 0);
		end_test("impulse", err_start);
	endtask

	// random taps and samples under random output stalls
	task automatic test_random_stream();
		int err_start;
		err_start = errors;
		for (int k = 0; k < NUM_TAPS; k++)
			write_coef(k, fir_pkg::coef_t'($urandom));
		set_switches(32'h0000_0006);
		for (int i = 0; i < 96; i++)
			run_sample("random stream", fir_pkg::sample_t'($urandom), int'($urandom % 8));
		end_test("random_stream", err_start);
	endtask

/* dv/fir_tb.sv */
`timescale 1ns/1ps

module fir_tb;

	localparam int TAPS_PER_LANE = 4;
	localparam int NUM_TAPS = 2 * TAPS_PER_LANE;
	localparam int LATENCY = TAPS_PER_LANE + 2;    // accept edge to out_valid
	localparam int TIMEOUT_CYCLES = 20000;

	logic S_AXI_ACLK;
	logic S_AXI_ARESETN;
	logic [fir_pkg::AXI_ADDR_W-1:0] awaddr;
	logic [fir_pkg::AXI_ADDR_W-1:0] araddr;
	logic awvalid;
	logic awready;
	logic wvalid;
	logic wready;
	logic bvalid;
	logic bready;
	logic arvalid;
	logic arready;
	logic rvalid;
	logic rready;
	logic [3:0] wstrb;
	logic [1:0] bresp;
	logic [1:0] rresp;
	fir_pkg::axi_data_t wdata;
	fir_pkg::axi_data_t rdata;
	logic in_valid;
	logic in_ready;
	logic out_valid;
	logic out_ready;
	fir_pkg::sample_t in_sample;
	fir_pkg::sample_t out_sample;
	logic [7:0] leds;

	int cycles = 0;
	int errors = 0;
	int checks = 0;
	int tests_run = 0;
	logic filter_on;                      // mirror of switch bit 1
	fir_pkg::sample_t hist [NUM_TAPS];    // model delay line with the newest sample first
	fir_pkg::coef_t coefs [NUM_TAPS];

	fir_axi_top #(.TAPS_PER_LANE(TAPS_PER_LANE)) UUT (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.S_AXI_AWADDR(awaddr), .S_AXI_AWVALID(awvalid), .S_AXI_AWREADY(awready),
		.S_AXI_WDATA(wdata), .S_AXI_WSTRB(wstrb), .S_AXI_WVALID(wvalid),
		.S_AXI_WREADY(wready), .S_AXI_BRESP(bresp), .S_AXI_BVALID(bvalid),
		.S_AXI_BREADY(bready), .S_AXI_ARADDR(araddr), .S_AXI_ARVALID(arvalid),
		.S_AXI_ARREADY(arready), .S_AXI_RDATA(rdata), .S_AXI_RRESP(rresp),
		.S_AXI_RVALID(rvalid), .S_AXI_RREADY(rready),
		.in_valid(in_valid), .in_ready(in_ready), .in_sample(in_sample),
		.out_valid(out_valid), .out_ready(out_ready), .out_sample(out_sample),
		.leds(leds)
	);

	initial begin
		S_AXI_ACLK = 1'b0;
		forever #50 S_AXI_ACLK = ~S_AXI_ACLK;
	end

	// watchdog on the cycle count
	always @(posedge S_AXI_ACLK) begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout: run still going after %0d cycles", cycles);
			$display("Simulation failed");
			$finish;
		end
	end

	task automatic report_fail(string msg);
		errors++;
		$display("[FAIL] %0t: %s", $time, msg);
	endtask

	task automatic check_word(string what, fir_pkg::axi_data_t got, fir_pkg::axi_data_t exp);
		checks++;
		if (got !== exp)
			report_fail($sformatf("%s got %08h expected %08h", what, got, exp));
	endtask

	task automatic check_sample(string what, fir_pkg::sample_t got, fir_pkg::sample_t exp);
		checks++;
		if (got !== exp)
			report_fail($sformatf("%s got %0d expected %0d", what, got, exp));
	endtask

	task automatic check_flag(string what, logic got, logic exp);
		checks++;
		if (got !== exp)
			report_fail($sformatf("%s got %b expected %b", what, got, exp));
	endtask

	// software model of the filter rule on the delay line
	function automatic fir_pkg::sample_t model_step(fir_pkg::sample_t x);
		longint acc;
		for (int k = NUM_TAPS - 1; k > 0; k--)
			hist[k] = hist[k-1];
		hist[0] = x;
		acc = 0;
		for (int k = 0; k < NUM_TAPS; k++)
			acc += longint'(coefs[k]) * longint'(hist[k]);
		if (!filter_on)
			return x;    // bypass output while the chain still moves
		return fir_pkg::sample_t'(acc >>> 17);
	endfunction

	task automatic axi_write(fir_pkg::reg_addr_t word, fir_pkg::axi_data_t data);
		@(negedge S_AXI_ACLK);
		awaddr = {word, 2'b00};
		wdata = data;
		awvalid = 1'b1;
		wvalid = 1'b1;
		@(negedge S_AXI_ACLK);
		while (!awready) @(negedge S_AXI_ACLK);
		check_flag("wready with awready", wready, 1'b1);
		@(negedge S_AXI_ACLK);
		awvalid = 1'b0;
		wvalid = 1'b0;
		check_flag("awready single cycle", awready, 1'b0);
		check_flag("wready single cycle", wready, 1'b0);
		check_flag("bvalid after write", bvalid, 1'b1);
		check_word("bresp", fir_pkg::axi_data_t'(bresp), '0);
		bready = 1'b1;
		@(negedge S_AXI_ACLK);
		bready = 1'b0;
	endtask

	task automatic axi_read(fir_pkg::reg_addr_t word, output fir_pkg::axi_data_t data);
		@(negedge S_AXI_ACLK);
		araddr = {word, 2'b00};
		arvalid = 1'b1;
		@(negedge S_AXI_ACLK);
		while (!arready) @(negedge S_AXI_ACLK);
		@(negedge S_AXI_ACLK);
		arvalid = 1'b0;
		check_flag("arready single cycle", arready, 1'b0);
		while (!rvalid) @(negedge S_AXI_ACLK);
		data = rdata;
		check_word("rresp", fir_pkg::axi_data_t'(rresp), '0);
		rready = 1'b1;
		@(negedge S_AXI_ACLK);
		rready = 1'b0;
	endtask

	task automatic read_check(string what, fir_pkg::reg_addr_t word, fir_pkg::axi_data_t exp);
		fir_pkg::axi_data_t d;
		axi_read(word, d);
		check_word(what, d, exp);
	endtask

	task automatic set_switches(fir_pkg::axi_data_t data);
		axi_write(fir_pkg::REG_SWITCHES, data);
		filter_on = data[1];
	endtask

	// upper word bits carry junk that the slave drops
	task automatic write_coef(int k, fir_pkg::coef_t c);
		fir_pkg::axi_data_t junk;
		junk = $urandom;
		axi_write(fir_pkg::COEF_BASE + fir_pkg::reg_addr_t'(k), {junk[31:18], c});
		coefs[k] = c;
	endtask

	task automatic send_sample(fir_pkg::sample_t x, output int acc_cyc);
		@(negedge S_AXI_ACLK);
		in_sample = x;
		in_valid = 1'b1;
		while (!in_ready) @(negedge S_AXI_ACLK);
		acc_cyc = cycles + 1;               // accepted on the coming edge
		@(negedge S_AXI_ACLK);
		in_valid = 1'b0;
		in_sample = fir_pkg::sample_t'($urandom);   // bypass must use the latched copy
	endtask

	task automatic take_sample(int stall, output fir_pkg::sample_t y, output int seen_cyc);
		fir_pkg::sample_t first;
		while (!out_valid) @(negedge S_AXI_ACLK);
		seen_cyc = cycles;
		first = out_sample;
		if (stall > 0) begin
			repeat (stall) begin
				check_flag("in_ready while output waits", in_ready, 1'b0);
				@(negedge S_AXI_ACLK);
			end
			check_flag("out_valid held", out_valid, 1'b1);
			check_sample("out_sample held", out_sample, first);
		end
		y = out_sample;
		out_ready = 1'b1;
		@(negedge S_AXI_ACLK);
		out_ready = 1'b0;
		check_flag("out_valid after take", out_valid, 1'b0);   // no duplicate
	endtask

	task automatic run_sample(string what, fir_pkg::sample_t x, int stall);
		int t_acc;
		int t_out;
		fir_pkg::sample_t y;
		fir_pkg::sample_t exp;
		exp = model_step(x);
		send_sample(x, t_acc);
		take_sample(stall, y, t_out);
		check_sample(what, y, exp);
		check_word("latency", fir_pkg::axi_data_t'(t_out - t_acc), LATENCY);
	endtask

	task automatic end_test(string name, int err_start);
		tests_run++;
		if (errors == err_start)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d errors", name, errors - err_start);
	endtask

	`include "fir_tests.svh"

	initial begin
		void'($urandom(32'h2a5b_a717));
		S_AXI_ARESETN = 1'b0;
		awaddr = '0;
		araddr = '0;
		wdata = '0;
		wstrb = 4'hf;
		{awvalid, wvalid, bready, arvalid, rready} = '0;
		in_valid = 1'b0;
		in_sample = '0;
		out_ready = 1'b0;
		filter_on = 1'b0;
		for (int k = 0; k < NUM_TAPS; k++) begin
			hist[k] = '0;     // chain comes out of reset silent
			coefs[k] = '0;
		end
		repeat (3) @(negedge S_AXI_ACLK);
		S_AXI_ARESETN = 1'b1;
		test_id_regs();
		test_switches();
		test_bypass();
		test_impulse();
		test_random_stream();
		$display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

/* rtl/axi_lite_regs.sv */
`timescale 1ns/1ps

module axi_lite_regs #(
	parameter int TAPS_PER_LANE = 4
) (
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,
	// write address and data
	input logic [fir_pkg::AXI_ADDR_W-1:0] S_AXI_AWADDR,
	input logic S_AXI_AWVALID,
	output logic S_AXI_AWREADY,
	input fir_pkg::axi_data_t S_AXI_WDATA,
	input logic [3:0] S_AXI_WSTRB,
	input logic S_AXI_WVALID,
	output logic S_AXI_WREADY,
	// write response
	output logic [1:0] S_AXI_BRESP,
	output logic S_AXI_BVALID,
	input logic S_AXI_BREADY,
	// read address and data
	input logic [fir_pkg::AXI_ADDR_W-1:0] S_AXI_ARADDR,
	input logic S_AXI_ARVALID,
	output logic S_AXI_ARREADY,
	output fir_pkg::axi_data_t S_AXI_RDATA,
	output logic [1:0] S_AXI_RRESP,
	output logic S_AXI_RVALID,
	input logic S_AXI_RREADY,
	// towards the filter
	output fir_pkg::coef_wr_t coef_wr,
	output logic fir_en,
	output logic [7:0] leds
);

	localparam int NUM_TAPS = 2 * TAPS_PER_LANE;

	fir_pkg::reg_addr_t awaddr;
	fir_pkg::reg_addr_t araddr;
	fir_pkg::axi_data_t switches;
	fir_pkg::axi_data_t rd_mux;
	logic aw_ready;
	logic w_ready;
	logic aw_en;      // low while a write response is outstanding
	logic b_valid;
	logic ar_ready;
	logic r_valid;
	logic aw_accept;
	logic reg_wren;
	logic rd_en;
	logic coef_sel;

	assign S_AXI_AWREADY = aw_ready;
	assign S_AXI_WREADY = w_ready;
	assign S_AXI_BVALID = b_valid;
	assign S_AXI_BRESP = 2'b00;     // always OKAY
	assign S_AXI_ARREADY = ar_ready;
	assign S_AXI_RVALID = r_valid;
	assign S_AXI_RRESP = 2'b00;

	// address and data both present, no response pending
	assign aw_accept = !aw_ready && S_AXI_AWVALID && S_AXI_WVALID && aw_en;
	assign reg_wren = aw_ready && S_AXI_AWVALID && w_ready && S_AXI_WVALID;

	// awready and wready pulse together
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			aw_ready <= 1'b0;
			w_ready <= 1'b0;
			aw_en <= 1'b1;
		end else if (aw_accept) begin
			aw_ready <= 1'b1;
			w_ready <= 1'b1;
			aw_en <= 1'b0;
		end else begin
			aw_ready <= 1'b0;
			w_ready <= 1'b0;
			if (S_AXI_BREADY && b_valid)
				aw_en <= 1'b1;    // response taken, next write may start
		end
	end

	always_ff @(posedge S_AXI_ACLK) begin
		if (aw_accept)
			awaddr <= S_AXI_AWADDR[fir_pkg::AXI_ADDR_W-1:2]; // word address
	end

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN)
			b_valid <= 1'b0;
		else if (reg_wren && !b_valid)
			b_valid <= 1'b1;
		else if (S_AXI_BREADY && b_valid)
			b_valid <= 1'b0;
	end

	// switches register, byte strobes honoured
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			switches <= '0;       // start in bypass
		end else if (reg_wren && awaddr == fir_pkg::REG_SWITCHES) begin
			for (int b = 0; b < 4; b++) begin
				if (S_AXI_WSTRB[b])
					switches[8*b +: 8] <= S_AXI_WDATA[8*b +: 8];
			end
		end
	end

	assign fir_en = switches[fir_pkg::SW_FIR_EN];
	assign leds = switches[7:0];

	// coefficient slots, one word per tap
	assign coef_sel = (awaddr >= fir_pkg::COEF_BASE)
		&& (awaddr < fir_pkg::COEF_BASE + fir_pkg::reg_addr_t'(NUM_TAPS));
	assign coef_wr.en = reg_wren && coef_sel;
	assign coef_wr.tap = fir_pkg::tap_idx_t'(awaddr - fir_pkg::COEF_BASE);
	assign coef_wr.value = fir_pkg::coef_t'(S_AXI_WDATA[17:0]); // low 18 bits, signed

	// read address handshake
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN)
			ar_ready <= 1'b0;
		else
			ar_ready <= !ar_ready && S_AXI_ARVALID && !r_valid;
	end

	always_ff @(posedge S_AXI_ACLK) begin
		if (!ar_ready && S_AXI_ARVALID && !r_valid)
			araddr <= S_AXI_ARADDR[fir_pkg::AXI_ADDR_W-1:2];
	end

	assign rd_en = ar_ready && S_AXI_ARVALID && !r_valid;

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN)
			r_valid <= 1'b0;
		else if (rd_en)
			r_valid <= 1'b1;
		else if (r_valid && S_AXI_RREADY)
			r_valid <= 1'b0;
	end

	// read mux, coefficient slots and holes read 0
	always_comb begin
		case (araddr)
			fir_pkg::REG_NAME: rd_mux = fir_pkg::ID_NAME;
			fir_pkg::REG_VER: rd_mux = fir_pkg::ID_VER;
			fir_pkg::REG_TAPS: rd_mux = fir_pkg::axi_data_t'(NUM_TAPS);
			fir_pkg::REG_TM: rd_mux = fir_pkg::axi_data_t'(TAPS_PER_LANE);
			fir_pkg::REG_LANES: rd_mux = 32'd2;
			fir_pkg::REG_FRAC: rd_mux = fir_pkg::axi_data_t'(fir_pkg::COEF_FRAC);
			fir_pkg::REG_COEF_BASE_RD: rd_mux = fir_pkg::axi_data_t'(fir_pkg::COEF_BASE);
			fir_pkg::REG_SWITCHES: rd_mux = switches;
			default: rd_mux = '0;
		endcase
	end

	always_ff @(posedge S_AXI_ACLK) begin
		if (rd_en)
			S_AXI_RDATA <= rd_mux;  // held until rready
	end

endmodule

/* rtl/fir_axi_top.sv */
`timescale 1ns/1ps

module fir_axi_top #(
	parameter int TAPS_PER_LANE = 4
) (
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,
	input logic [fir_pkg::AXI_ADDR_W-1:0] S_AXI_AWADDR,
	input logic S_AXI_AWVALID,
	output logic S_AXI_AWREADY,
	input fir_pkg::axi_data_t S_AXI_WDATA,
	input logic [3:0] S_AXI_WSTRB,
	input logic S_AXI_WVALID,
	output logic S_AXI_WREADY,
	output logic [1:0] S_AXI_BRESP,
	output logic S_AXI_BVALID,
	input logic S_AXI_BREADY,
	input logic [fir_pkg::AXI_ADDR_W-1:0] S_AXI_ARADDR,
	input logic S_AXI_ARVALID,
	output logic S_AXI_ARREADY,
	output fir_pkg::axi_data_t S_AXI_RDATA,
	output logic [1:0] S_AXI_RRESP,
	output logic S_AXI_RVALID,
	input logic S_AXI_RREADY,
	// sample stream
	input logic in_valid,
	output logic in_ready,
	input fir_pkg::sample_t in_sample,
	output logic out_valid,
	input logic out_ready,
	output fir_pkg::sample_t out_sample,
	output logic [7:0] leds
);

	fir_pkg::coef_wr_t coef_wr;     // shared by both lanes
	fir_pkg::sample_t chain;        // lane 0 oldest into lane 1
	fir_pkg::acc_t sum_a;
	fir_pkg::acc_t sum_b;
	logic fir_en;
	logic start;
	logic done_a;
	logic done_b;

	axi_lite_regs #(.TAPS_PER_LANE(TAPS_PER_LANE)) regs (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.S_AXI_AWADDR(S_AXI_AWADDR), .S_AXI_AWVALID(S_AXI_AWVALID),
		.S_AXI_AWREADY(S_AXI_AWREADY),
		.S_AXI_WDATA(S_AXI_WDATA), .S_AXI_WSTRB(S_AXI_WSTRB),
		.S_AXI_WVALID(S_AXI_WVALID), .S_AXI_WREADY(S_AXI_WREADY),
		.S_AXI_BRESP(S_AXI_BRESP), .S_AXI_BVALID(S_AXI_BVALID),
		.S_AXI_BREADY(S_AXI_BREADY),
		.S_AXI_ARADDR(S_AXI_ARADDR), .S_AXI_ARVALID(S_AXI_ARVALID),
		.S_AXI_ARREADY(S_AXI_ARREADY),
		.S_AXI_RDATA(S_AXI_RDATA), .S_AXI_RRESP(S_AXI_RRESP),
		.S_AXI_RVALID(S_AXI_RVALID), .S_AXI_RREADY(S_AXI_RREADY),
		.coef_wr(coef_wr), .fir_en(fir_en), .leds(leds)
	);

	// lane 0 owns taps 0..TAPS_PER_LANE-1 and takes the new sample
	fir_mac_lane #(.TAPS_PER_LANE(TAPS_PER_LANE), .LANE_BASE(0)) lane0 (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.coef_wr(coef_wr), .start(start), .sample_in(in_sample),
		.sample_out(chain), .sum(sum_a), .done(done_a)
	);

	// lane 1 continues the delay line, its oldest sample falls off the end
	fir_mac_lane #(.TAPS_PER_LANE(TAPS_PER_LANE), .LANE_BASE(TAPS_PER_LANE)) lane1 (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.coef_wr(coef_wr), .start(start), .sample_in(chain),
		.sample_out(), .sum(sum_b), .done(done_b)
	);

	fir_combine #(.TAPS_PER_LANE(TAPS_PER_LANE)) combine (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.in_valid(in_valid), .in_ready(in_ready), .in_sample(in_sample),
		.fir_en(fir_en), .start(start),
		.sum_a(sum_a), .sum_b(sum_b), .done_a(done_a), .done_b(done_b),
		.out_valid(out_valid), .out_ready(out_ready), .out_sample(out_sample)
	);

endmodule

/* rtl/fir_combine.sv */
`timescale 1ns/1ps

module fir_combine #(
	parameter int TAPS_PER_LANE = 4
) (
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,
	input logic in_valid,
	output logic in_ready,
	input fir_pkg::sample_t in_sample,
	input logic fir_en,
	output logic start,
	input fir_pkg::acc_t sum_a,
	input fir_pkg::acc_t sum_b,
	input logic done_a,
	input logic done_b,
	output logic out_valid,
	input logic out_ready,
	output fir_pkg::sample_t out_sample
);

	// full width of both lanes added, guard bits grow with the tap count
	localparam int SUM_W = $bits(fir_pkg::sample_t) + $bits(fir_pkg::coef_t)
		+ $clog2(2 * TAPS_PER_LANE);

	fir_pkg::seq_state_t state;
	fir_pkg::sample_t byp_sample;     // x[n] kept for bypass
	fir_pkg::sample_t filt;
	logic signed [SUM_W-1:0] comb_sum;
	logic lanes_done;

	assign in_ready = (state == fir_pkg::SEQ_IDLE);
	assign start = in_valid && in_ready;    // accept edge kicks both lanes
	assign out_valid = (state == fir_pkg::SEQ_HOLD);
	assign lanes_done = done_a && done_b;

	assign comb_sum = sum_a + sum_b;
	assign filt = fir_pkg::sample_t'(comb_sum >>> fir_pkg::COEF_FRAC); // drop fraction, wrap

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			state <= fir_pkg::SEQ_IDLE;
		end else begin
			case (state)
				fir_pkg::SEQ_IDLE: if (in_valid) state <= fir_pkg::SEQ_RUN;
				fir_pkg::SEQ_RUN: if (lanes_done) state <= fir_pkg::SEQ_HOLD;
				fir_pkg::SEQ_HOLD: if (out_ready) state <= fir_pkg::SEQ_IDLE;
				default: state <= fir_pkg::SEQ_IDLE;
			endcase
		end
	end

	// result held through back-pressure
	always_ff @(posedge S_AXI_ACLK) begin
		if (start)
			byp_sample <= in_sample;
		if (state == fir_pkg::SEQ_RUN && lanes_done)
			out_sample <= fir_en ? filt : byp_sample;
	end

endmodule

/* rtl/fir_mac_lane.sv */
`timescale 1ns/1ps

module fir_mac_lane #(
	parameter int TAPS_PER_LANE = 4,
	parameter int LANE_BASE = 0       // first global tap owned here
) (
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,
	input fir_pkg::coef_wr_t coef_wr,
	input logic start,
	input fir_pkg::sample_t sample_in,
	output fir_pkg::sample_t sample_out,
	output fir_pkg::acc_t sum,
	output logic done
);

	localparam int SLOT_W = (TAPS_PER_LANE > 1) ? $clog2(TAPS_PER_LANE) : 1;
	localparam int PROD_W = $bits(fir_pkg::sample_t) + $bits(fir_pkg::coef_t);
	localparam logic [SLOT_W-1:0] LAST_SLOT = SLOT_W'(TAPS_PER_LANE - 1);

	fir_pkg::sample_t seg [TAPS_PER_LANE];      // newest at index 0
	fir_pkg::coef_t coef_mem [TAPS_PER_LANE];
	fir_pkg::tap_idx_t coef_rel;
	logic coef_hit;
	logic [SLOT_W-1:0] slot;
	logic busy;         // multiplier phase
	logic mul_vld;      // prod holds a fresh product
	logic mul_last;
	logic signed [PROD_W-1:0] prod;
	fir_pkg::acc_t acc;

	// oldest sample leaves towards the next lane
	assign sample_out = seg[TAPS_PER_LANE-1];

	// keep only taps in this lane's range
	assign coef_rel = coef_wr.tap - fir_pkg::tap_idx_t'(LANE_BASE);
	assign coef_hit = coef_wr.en && (int'(coef_wr.tap) >= LANE_BASE)
		&& (int'(coef_wr.tap) < LANE_BASE + TAPS_PER_LANE);

	always_ff @(posedge S_AXI_ACLK) begin
		if (coef_hit)
			coef_mem[coef_rel[SLOT_W-1:0]] <= coef_wr.value;
	end

	// sample segment, cleared so the chain starts from silence
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			for (int i = 0; i < TAPS_PER_LANE; i++)
				seg[i] <= '0;
		end else if (start) begin
			seg[0] <= sample_in;
			for (int i = 1; i < TAPS_PER_LANE; i++)
				seg[i] <= seg[i-1];
		end
	end

	// slot counter, one tap per cycle
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			busy <= 1'b0;
			slot <= '0;
			mul_vld <= 1'b0;
			mul_last <= 1'b0;
			done <= 1'b0;
		end else begin
			mul_vld <= busy;
			mul_last <= busy && (slot == LAST_SLOT);
			done <= mul_last;   // lines up with the last accumulate
			if (start) begin
				busy <= 1'b1;
				slot <= '0;
			end else if (busy) begin
				slot <= slot + 1'b1;
				if (slot == LAST_SLOT)
					busy <= 1'b0;
			end
		end
	end

	// registered multiplier feeding the accumulator
	always_ff @(posedge S_AXI_ACLK) begin
		if (busy)
			prod <= coef_mem[slot] * seg[slot];
	end

	always_ff @(posedge S_AXI_ACLK) begin
		if (start)
			acc <= '0;                  // fresh sum per sample
		else if (mul_vld)
			acc <= acc + prod;
	end

	assign sum = acc;

endmodule

/* rtl/fir_pkg.sv */
package fir_pkg;

	// sample and arithmetic widths
	typedef logic signed [13:0] sample_t;   // stream sample in and out
	typedef logic signed [17:0] coef_t;     // q1.17 coefficient
	typedef logic signed [34:0] acc_t;      // 14 + 18 + 3 guard bits for 8 products

	// bus side widths
	typedef logic [31:0] axi_data_t;
	typedef logic [13:0] reg_addr_t;        // word address, byte bits dropped
	typedef logic [2:0] tap_idx_t;          // global tap number

	// coefficient write broadcast to the lanes
	typedef struct packed {
		logic en;
		tap_idx_t tap;
		coef_t value;
	} coef_wr_t;

	// stream sequencer
	typedef enum logic [1:0] {
		SEQ_IDLE,   // waiting for a sample, in_ready high
		SEQ_RUN,    // lanes busy
		SEQ_HOLD    // result on out_sample until out_ready
	} seq_state_t;

	localparam int COEF_FRAC = 17;                   // fractional bits dropped from the sum
	localparam int AXI_ADDR_W = $bits(reg_addr_t) + 2; // byte address width

	// identification words
	localparam axi_data_t ID_NAME = "FIR ";
	localparam axi_data_t ID_VER = "02.3";

	// register map, word addresses
	localparam reg_addr_t REG_NAME = 14'd0;
	localparam reg_addr_t REG_VER = 14'd1;
	localparam reg_addr_t REG_TAPS = 14'd4;
	localparam reg_addr_t REG_TM = 14'd8;
	localparam reg_addr_t REG_LANES = 14'd9;
	localparam reg_addr_t REG_FRAC = 14'd12;
	localparam reg_addr_t REG_COEF_BASE_RD = 14'd16;
	localparam reg_addr_t REG_SWITCHES = 14'd20;
	localparam reg_addr_t COEF_BASE = 14'd64;        // tap k lives at COEF_BASE + k

	localparam int SW_FIR_EN = 1;                    // switch bit, 1 filters and 0 bypasses

endpackage

/* run_sim.sh */
#!/bin/sh
# build and run the FIR testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal -f src.f --top-module fir_tb -o fir_sim
out=$(./obj_dir/fir_sim)
echo "$out"
if echo "$out" | grep -qx "Simulation passed"; then
	exit 0
fi
exit 1

/* src.f */
+incdir+dv
rtl/fir_pkg.sv
rtl/axi_lite_regs.sv
rtl/fir_mac_lane.sv
rtl/fir_combine.sv
rtl/fir_axi_top.sv
dv/fir_tb.sv
